// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_memtest -f sources.f -o tb_memtest &&
./obj_dir/tb_memtest ||
{ echo "run.sh: build or simulation error"; exit 1; }

// ==== source/memtest_pkg.sv ====
package memtest_pkg;

    // OBI bus widths
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;

    // SRAM geometry, addresses wrap modulo the array size
    localparam int unsigned MEM_WORDS = 256;
    localparam int unsigned MEM_AW = $clog2(MEM_WORDS);

    // register port and field widths
    localparam int unsigned REG_ADDR_W = 4;
    localparam int unsigned COUNT_W = 16;
    localparam int unsigned STALL_W = 8;

    // register map
    localparam logic [REG_ADDR_W-1:0] REG_CTRL      = REG_ADDR_W'(0);
    localparam logic [REG_ADDR_W-1:0] REG_BASE      = REG_ADDR_W'(1);
    localparam logic [REG_ADDR_W-1:0] REG_COUNT     = REG_ADDR_W'(2);
    localparam logic [REG_ADDR_W-1:0] REG_SEED      = REG_ADDR_W'(3);
    localparam logic [REG_ADDR_W-1:0] REG_STALL     = REG_ADDR_W'(4);
    localparam logic [REG_ADDR_W-1:0] REG_STATUS    = REG_ADDR_W'(5);
    localparam logic [REG_ADDR_W-1:0] REG_ERRORS    = REG_ADDR_W'(6);
    localparam logic [REG_ADDR_W-1:0] REG_FIRST_ERR = REG_ADDR_W'(7);
    localparam logic [REG_ADDR_W-1:0] REG_INJECT    = REG_ADDR_W'(8);

    typedef enum logic [2:0] {
        IDLE,
        WR_REQ,
        WR_RSP,
        RD_REQ,
        RD_RSP,
        DONE
    } gen_state_t;

    typedef enum logic {
        SIZE_WORD,
        SIZE_HALF
    } access_size_t;

endpackage : memtest_pkg

// ==== source/memtest_regs.sv ====
`timescale 1ns/1ns

module memtest_regs
    import memtest_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cfg_we_i,
    input  logic                  cfg_re_i,
    input  logic [REG_ADDR_W-1:0] cfg_addr_i,
    input  logic [DATA_W-1:0]     cfg_wdata_i,
    input  logic                  busy_i,
    input  logic                  done_i,
    input  logic                  err_i,
    input  logic [ADDR_W-1:0]     err_addr_i,
    output logic [DATA_W-1:0]     cfg_rdata_o,
    output logic                  start_o,
    output logic [ADDR_W-1:0]     base_o,
    output logic [COUNT_W-1:0]    count_o,
    output logic [DATA_W-1:0]     seed_o,
    output access_size_t          size_o,
    output logic [STALL_W-1:0]    stall_o,
    output logic                  inject_en_o,
    output logic [ADDR_W-1:0]     inject_addr_o
);

    logic                 ctrl_wr;
    logic                 done_q;
    logic [COUNT_W-1:0]   err_cnt_q;
    logic [ADDR_W-1:0]    first_err_q;
    logic [DATA_W-1:0]    rdata_d;

    assign ctrl_wr = cfg_we_i && (cfg_addr_i == REG_CTRL);

    // configuration registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base_o        <= '0;
            count_o       <= '0;
            seed_o        <= '0;
            size_o        <= SIZE_WORD;
            stall_o       <= '0;
            inject_en_o   <= 1'b0;
            inject_addr_o <= '0;
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                REG_CTRL: begin
                    size_o      <= access_size_t'(cfg_wdata_i[1]);
                    inject_en_o <= cfg_wdata_i[2];
                end
                REG_BASE:   base_o        <= cfg_wdata_i;
                REG_COUNT:  count_o       <= cfg_wdata_i[COUNT_W-1:0];
                REG_SEED:   seed_o        <= cfg_wdata_i;
                REG_STALL:  stall_o       <= cfg_wdata_i[STALL_W-1:0];
                REG_INJECT: inject_addr_o <= cfg_wdata_i;
                default: ;
            endcase
        end
    end

    // start pulse, blocked while a run is active or one is just launching
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_o <= 1'b0;
        end else begin
            start_o <= ctrl_wr && cfg_wdata_i[0] && !busy_i && !start_o;
        end
    end

    // run results, cleared by each start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q      <= 1'b0;
            err_cnt_q   <= '0;
            first_err_q <= '0;
        end else if (start_o) begin
            done_q      <= 1'b0;
            err_cnt_q   <= '0;
            first_err_q <= '0;
        end else begin
            if (done_i) begin
                done_q <= 1'b1;
            end
            if (err_i) begin
                if (err_cnt_q == '0) begin
                    first_err_q <= err_addr_i;
                end
                // saturate
                if (err_cnt_q != '1) begin
                    err_cnt_q <= err_cnt_q + 1'b1;
                end
            end
        end
    end

    always_comb begin
        rdata_d = '0;
        case (cfg_addr_i)
            REG_CTRL: begin
                rdata_d[1] = (size_o == SIZE_HALF);
                rdata_d[2] = inject_en_o;
            end
            REG_BASE:      rdata_d = base_o;
            REG_COUNT:     rdata_d[COUNT_W-1:0] = count_o;
            REG_SEED:      rdata_d = seed_o;
            REG_STALL:     rdata_d[STALL_W-1:0] = stall_o;
            REG_STATUS: begin
                rdata_d[0] = busy_i;
                rdata_d[1] = done_q;
            end
            REG_ERRORS:    rdata_d[COUNT_W-1:0] = err_cnt_q;
            REG_FIRST_ERR: rdata_d = first_err_q;
            REG_INJECT:    rdata_d = inject_addr_o;
            default:       rdata_d = '0;
        endcase
    end

    // read data lands one cycle after the strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_rdata_o <= '0;
        end else if (cfg_re_i) begin
            cfg_rdata_o <= rdata_d;
        end
    end

    a_no_start_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n) start_o |-> !busy_i
    ) else $error("start pulse while generator busy");

endmodule : memtest_regs

// ==== source/memtest_top.sv ====
`timescale 1ns/1ns

module memtest_top
    import memtest_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cfg_we_i,
    input  logic                  cfg_re_i,
    input  logic [REG_ADDR_W-1:0] cfg_addr_i,
    input  logic [DATA_W-1:0]     cfg_wdata_i,
    output logic [DATA_W-1:0]     cfg_rdata_o
);

    // register block to generator
    logic                 start;
    logic [ADDR_W-1:0]    base;
    logic [COUNT_W-1:0]   count;
    logic [DATA_W-1:0]    seed;
    access_size_t         size;
    logic                 busy;
    logic                 done;
    logic                 err;
    logic [ADDR_W-1:0]    err_addr;

    // register block to memory
    logic [STALL_W-1:0]   stall;
    logic                 inject_en;
    logic [ADDR_W-1:0]    inject_addr;

    // internal OBI
    logic                 obi_req;
    logic                 obi_gnt;
    logic [ADDR_W-1:0]    obi_addr;
    logic                 obi_we;
    logic [DATA_W/8-1:0]  obi_be;
    logic [DATA_W-1:0]    obi_wdata;
    logic                 obi_rvalid;
    logic [DATA_W-1:0]    obi_rdata;

    memtest_regs u_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_we_i      (cfg_we_i),
        .cfg_re_i      (cfg_re_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_wdata_i   (cfg_wdata_i),
        .busy_i        (busy),
        .done_i        (done),
        .err_i         (err),
        .err_addr_i    (err_addr),
        .cfg_rdata_o   (cfg_rdata_o),
        .start_o       (start),
        .base_o        (base),
        .count_o       (count),
        .seed_o        (seed),
        .size_o        (size),
        .stall_o       (stall),
        .inject_en_o   (inject_en),
        .inject_addr_o (inject_addr)
    );

    obi_traffic_gen u_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start),
        .base_i     (base),
        .count_i    (count),
        .seed_i     (seed),
        .size_i     (size),
        .gnt_i      (obi_gnt),
        .rvalid_i   (obi_rvalid),
        .rdata_i    (obi_rdata),
        .busy_o     (busy),
        .done_o     (done),
        .err_o      (err),
        .err_addr_o (err_addr),
        .req_o      (obi_req),
        .addr_o     (obi_addr),
        .we_o       (obi_we),
        .be_o       (obi_be),
        .wdata_o    (obi_wdata)
    );

    obi_sram u_sram (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_i         (obi_req),
        .addr_i        (obi_addr),
        .we_i          (obi_we),
        .be_i          (obi_be),
        .wdata_i       (obi_wdata),
        .stall_i       (stall),
        .inject_en_i   (inject_en),
        .inject_addr_i (inject_addr),
        .gnt_o         (obi_gnt),
        .rvalid_o      (obi_rvalid),
        .rdata_o       (obi_rdata)
    );

endmodule : memtest_top

// ==== source/obi_sram.sv ====
`timescale 1ns/1ns

module obi_sram
    import memtest_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_i,
    input  logic [ADDR_W-1:0]     addr_i,
    input  logic                  we_i,
    input  logic [DATA_W/8-1:0]   be_i,
    input  logic [DATA_W-1:0]     wdata_i,
    input  logic [STALL_W-1:0]    stall_i,
    input  logic                  inject_en_i,
    input  logic [ADDR_W-1:0]     inject_addr_i,
    output logic                  gnt_o,
    output logic                  rvalid_o,
    output logic [DATA_W-1:0]     rdata_o
);

    logic [DATA_W-1:0]           mem [MEM_WORDS];
    logic [STALL_W-1:0]          pattern;
    logic [$clog2(STALL_W)-1:0]  ptr_q;
    logic [MEM_AW-1:0]           word_idx;
    logic                        inject_hit;
    logic [DATA_W-1:0]           flip_mask;
    logic [DATA_W-1:0]           rdata_q;
    logic                        rvalid_q;

    // empty pattern means never stall
    assign pattern  = (stall_i == '0) ? '1 : stall_i;
    assign gnt_o    = req_i && pattern[ptr_q];
    assign word_idx = addr_i[MEM_AW+1:2];

    assign inject_hit = inject_en_i && (word_idx == inject_addr_i[MEM_AW+1:2]);

    // bit0 of the lowest enabled lane
    always_comb begin
        flip_mask = '0;
        for (int i = DATA_W/8 - 1; i >= 0; i--) begin
            if (be_i[i]) begin
                flip_mask = DATA_W'(1) << (8 * i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q    <= '0;
            rvalid_q <= 1'b0;
        end else begin
            if (req_i) begin
                ptr_q <= ptr_q + 1'b1;
            end
            rvalid_q <= gnt_o;
        end
    end

    always_ff @(posedge clk) begin
        if (gnt_o) begin
            if (we_i) begin
                for (int i = 0; i < DATA_W/8; i++) begin
                    if (be_i[i]) begin
                        mem[word_idx][8*i +: 8] <= wdata_i[8*i +: 8];
                    end
                end
            end else begin
                rdata_q <= mem[word_idx] ^ (inject_hit ? flip_mask : '0);
            end
        end
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;

    a_rvalid_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) rvalid_o |=> !rvalid_o
    ) else $error("rvalid held for more than one cycle after a grant");

endmodule : obi_sram

// ==== source/obi_traffic_gen.sv ====
`timescale 1ns/1ns

module obi_traffic_gen
    import memtest_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  logic [ADDR_W-1:0]     base_i,
    input  logic [COUNT_W-1:0]    count_i,
    input  logic [DATA_W-1:0]     seed_i,
    input  access_size_t          size_i,
    input  logic                  gnt_i,
    input  logic                  rvalid_i,
    input  logic [DATA_W-1:0]     rdata_i,
    output logic                  busy_o,
    output logic                  done_o,
    output logic                  err_o,
    output logic [ADDR_W-1:0]     err_addr_o,
    output logic                  req_o,
    output logic [ADDR_W-1:0]     addr_o,
    output logic                  we_o,
    output logic [DATA_W/8-1:0]   be_o,
    output logic [DATA_W-1:0]     wdata_o
);

    gen_state_t state, state_n;

    logic [COUNT_W-1:0]   count_q;
    logic [COUNT_W-1:0]   idx_q;
    access_size_t         size_q;
    logic [ADDR_W-1:0]    base_q;
    logic [ADDR_W-1:0]    addr_q;
    logic [DATA_W-1:0]    seed_q;
    logic [ADDR_W-1:0]    step;
    logic [DATA_W-1:0]    pattern;
    logic [DATA_W-1:0]    lane_mask;
    logic                 launch;
    logic                 advance;
    logic                 last;
    logic                 mismatch;

    assign launch  = ((state == IDLE) || (state == DONE)) && start_i;
    assign advance = ((state == WR_RSP) || (state == RD_RSP)) && rvalid_i;
    assign last    = (idx_q == count_q - 1'b1);
    assign step    = (size_q == SIZE_HALF) ? ADDR_W'(2) : ADDR_W'(4);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_n;
        end
    end

    // one transfer outstanding at a time
    always_comb begin
        state_n = state;
        case (state)
            IDLE, DONE: begin
                if (start_i) begin
                    state_n = (count_i == '0) ? DONE : WR_REQ;
                end else begin
                    state_n = IDLE;
                end
            end
            WR_REQ: begin
                if (gnt_i) begin
                    state_n = WR_RSP;
                end
            end
            WR_RSP: begin
                if (rvalid_i) begin
                    state_n = last ? RD_REQ : WR_REQ;
                end
            end
            RD_REQ: begin
                if (gnt_i) begin
                    state_n = RD_RSP;
                end
            end
            RD_RSP: begin
                if (rvalid_i) begin
                    state_n = last ? DONE : RD_REQ;
                end
            end
            default: state_n = IDLE;
        endcase
    end

    // run settings and transfer index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
            idx_q   <= '0;
            size_q  <= SIZE_WORD;
        end else if (launch) begin
            count_q <= count_i;
            idx_q   <= '0;
            size_q  <= size_i;
        end else if (advance) begin
            idx_q <= last ? '0 : idx_q + 1'b1;
        end
    end

    // address walks the range twice, once per pass
    always_ff @(posedge clk) begin
        if (launch) begin
            base_q <= base_i;
            addr_q <= base_i;
            seed_q <= seed_i;
        end else if (advance) begin
            addr_q <= last ? base_q : addr_q + step;
        end
    end

    assign pattern = addr_q ^ seed_q;

    always_comb begin
        if (size_q == SIZE_WORD) begin
            be_o = 4'b1111;
        end else if (addr_q[1]) begin
            be_o = 4'b1100;
        end else begin
            be_o = 4'b0011;
        end
    end

    always_comb begin
        for (int i = 0; i < DATA_W/8; i++) begin
            lane_mask[8*i +: 8] = {8{be_o[i]}};
        end
    end

    // only enabled lanes take part in the compare
    assign mismatch = |((rdata_i ^ pattern) & lane_mask);

    assign busy_o     = (state != IDLE) && (state != DONE);
    assign done_o     = (state == DONE);
    assign req_o      = (state == WR_REQ) || (state == RD_REQ);
    assign we_o       = (state == WR_REQ);
    assign addr_o     = addr_q;
    assign wdata_o    = pattern;
    assign err_o      = (state == RD_RSP) && rvalid_i && mismatch;
    assign err_addr_o = addr_q;

    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (req_o && !gnt_i) |=> (req_o && $stable(addr_o) && $stable(we_o)
                               && $stable(be_o) && $stable(wdata_o))
    ) else $error("OBI request changed before grant");

    a_no_early_rvalid: assert property (
        @(posedge clk) disable iff (!rst_n)
        rvalid_i |-> ((state != WR_REQ) && (state != RD_REQ))
    ) else $error("rvalid while a request is pending");

endmodule : obi_traffic_gen

// ==== sources.f ====
source/memtest_pkg.sv
source/memtest_regs.sv
source/obi_traffic_gen.sv
source/obi_sram.sv
source/memtest_top.sv
testbench/tb_memtest.sv

// ==== testbench/tb_memtest.sv ====
`timescale 1ns/1ns

module tb_memtest
    import memtest_pkg::*;
;

    localparam int unsigned DRIVE_DLY = 10;
    localparam int unsigned MAX_POLLS = 5000;

    logic                  clk;
    logic                  rst_n;
    logic                  cfg_we;
    logic                  cfg_re;
    logic [REG_ADDR_W-1:0] cfg_addr;
    logic [DATA_W-1:0]     cfg_wdata;
    logic [DATA_W-1:0]     cfg_rdata;

    logic [31:0] rng_state;
    logic [31:0] model_mem [256];

    memtest_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_we_i    (cfg_we),
        .cfg_re_i    (cfg_re),
        .cfg_addr_i  (cfg_addr),
        .cfg_wdata_i (cfg_wdata),
        .cfg_rdata_o (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] rand_next();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [3:0] lane_enables(input logic half, input logic [31:0] addr);
        if (!half) begin
            return 4'b1111;
        end
        return addr[1] ? 4'b1100 : 4'b0011;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR: %s is 0x%08h, expected 0x%08h", name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        next_cycle();
        cfg_we    = 1'b0;
    endtask

    // read data is registered, valid after the capturing edge
    task automatic read_reg(input logic [REG_ADDR_W-1:0] addr, output logic [31:0] data);
        cfg_re   = 1'b1;
        cfg_addr = addr;
        next_cycle();
        cfg_re   = 1'b0;
        data     = cfg_rdata;
    endtask

    task automatic wait_for_done();
        logic [31:0] status;
        int unsigned polls;
        status = '0;
        polls  = 0;
        while (status[1] == 1'b0) begin
            if (polls == MAX_POLLS) begin
                $display("timeout: run did not finish within %0d status polls", MAX_POLLS);
                $display("SIMULATION FAILED");
                $fatal(1, "run timeout");
            end
            read_reg(REG_STATUS, status);
            polls++;
        end
    endtask

    // write pass then read pass over a byte-lane memory image
    task automatic run_model(input logic [31:0] base, input logic [31:0] count,
                             input logic [31:0] seed, input logic half,
                             input logic inj_en, input logic [31:0] inj_addr,
                             output logic [15:0] errors, output logic [31:0] first);
        logic [31:0] addr;
        logic [31:0] step;
        logic [31:0] expect_data;
        logic [31:0] data;
        logic [31:0] mask;
        logic [3:0]  be;
        logic [7:0]  widx;
        int          low_lane;
        errors = '0;
        first  = '0;
        step   = half ? 32'd2 : 32'd4;
        addr   = base;
        for (int unsigned i = 0; i < count; i++) begin
            be          = lane_enables(half, addr);
            widx        = addr[9:2];
            expect_data = addr ^ seed;
            for (int l = 0; l < 4; l++) begin
                if (be[l]) begin
                    model_mem[widx][8*l +: 8] = expect_data[8*l +: 8];
                end
            end
            addr = addr + step;
        end
        addr = base;
        for (int unsigned i = 0; i < count; i++) begin
            be          = lane_enables(half, addr);
            widx        = addr[9:2];
            expect_data = addr ^ seed;
            data        = model_mem[widx];
            low_lane    = 0;
            for (int l = 3; l >= 0; l--) begin
                mask[8*l +: 8] = {8{be[l]}};
                if (be[l]) begin
                    low_lane = l;
                end
            end
            if (inj_en && (widx == inj_addr[9:2])) begin
                data[8*low_lane] = ~data[8*low_lane];
            end
            if (((data ^ expect_data) & mask) != 32'd0) begin
                if (errors == 16'd0) begin
                    first = addr;
                end
                errors = errors + 16'd1;
            end
            addr = addr + step;
        end
    endtask

    task automatic run_test(input logic [31:0] base, input logic [31:0] count,
                            input logic [31:0] seed, input logic half,
                            input logic [7:0] stall, input logic inj_en,
                            input logic [31:0] inj_addr);
        logic [31:0] rdata;
        logic [31:0] ctrl;
        logic [15:0] exp_errors;
        logic [31:0] exp_first;
        ctrl = {29'd0, inj_en, half, 1'b0};
        write_reg(REG_BASE, base);
        write_reg(REG_COUNT, count);
        write_reg(REG_SEED, seed);
        write_reg(REG_STALL, 32'(stall));
        write_reg(REG_INJECT, inj_addr);
        write_reg(REG_CTRL, ctrl);

        read_reg(REG_BASE, rdata);
        check_value("BASE", rdata, base);
        read_reg(REG_COUNT, rdata);
        check_value("COUNT", rdata, count);
        read_reg(REG_SEED, rdata);
        check_value("SEED", rdata, seed);
        read_reg(REG_STALL, rdata);
        check_value("STALL", rdata, 32'(stall));
        read_reg(REG_INJECT, rdata);
        check_value("INJECT", rdata, inj_addr);
        read_reg(REG_CTRL, rdata);
        check_value("CTRL", rdata, ctrl);

        write_reg(REG_CTRL, ctrl | 32'h1);
        // start pulse needs one cycle to clear the old results
        next_cycle();
        read_reg(REG_STATUS, rdata);
        check_value("STATUS after start", rdata, 32'h1);
        read_reg(REG_ERRORS, rdata);
        check_value("ERRORS after start", rdata, 32'h0);

        wait_for_done();
        run_model(base, count, seed, half, inj_en, inj_addr, exp_errors, exp_first);
        read_reg(REG_STATUS, rdata);
        check_value("STATUS", rdata, 32'h2);
        read_reg(REG_ERRORS, rdata);
        check_value("ERRORS", rdata, 32'(exp_errors));
        read_reg(REG_FIRST_ERR, rdata);
        check_value("FIRST_ERR", rdata, exp_first);
    endtask

    initial begin
        logic [31:0] rdata;
        logic [31:0] r;
        logic [31:0] base;
        logic [31:0] count;
        logic [31:0] seed;
        logic [31:0] inj_addr;
        logic [7:0]  stall;
        logic        half;
        logic        inj_en;

        rst_n     = 1'b0;
        cfg_we    = 1'b0;
        cfg_re    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        rng_state = 32'd84813;

        repeat (16) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        next_cycle();

        read_reg(REG_STATUS, rdata);
        check_value("STATUS after reset", rdata, 32'h0);
        read_reg(REG_ERRORS, rdata);
        check_value("ERRORS after reset", rdata, 32'h0);

        // word mode, injection address set but disabled
        run_test(32'h0000_0100, 32'd16, 32'hA5A5_5A5A, 1'b0, 8'hFF, 1'b0, 32'h0000_0110);
        // halfword mode from an odd halfword, two hits in one word
        run_test(32'h0000_0202, 32'd21, 32'h1357_9BDF, 1'b1, 8'h5A, 1'b1, 32'h0000_020A);
        // range wraps past the top of the SRAM
        run_test(32'h0000_03F0, 32'd32, 32'hDEAD_BEEF, 1'b0, 8'h00, 1'b1, 32'h0000_0008);

        for (int n = 0; n < 10; n++) begin
            r     = rand_next();
            half  = r[0];
            inj_en = r[1];
            base  = rand_next();
            base  = half ? {base[31:1], 1'b0} : {base[31:2], 2'b00};
            count = (rand_next() % 32'd64) + 32'd1;
            seed  = rand_next();
            stall = r[15:8];
            if (n % 3 == 0) begin
                stall = 8'h00;
            end
            inj_addr = base + (rand_next() % count) * (half ? 32'd2 : 32'd4);
            if (r[4]) begin
                inj_addr = rand_next();
            end
            run_test(base, count, seed, half, stall, inj_en, inj_addr);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule : tb_memtest
